//--- hw/matrix_pkg.sv
package matrix_pkg;

    // matrix geometry
    localparam int DATA_WIDTH = 9;
    localparam int MAX_DIM    = 5;
    localparam int CELL_COUNT = MAX_DIM * MAX_DIM;
    localparam int DIM_WIDTH  = 3;

    // one cell, unsigned in effect
    typedef logic [DATA_WIDTH-1:0] cell_t;

    // size or row index, 1..5 for sizes
    typedef logic [DIM_WIDTH-1:0] dim_t;

    // cell j of a row sits at index j
    typedef cell_t [MAX_DIM-1:0] row_t;

    // row i of the grid sits at index i
    typedef row_t [MAX_DIM-1:0] grid_t;

    // row-major list, cell k at index k
    typedef cell_t [CELL_COUNT-1:0] flat_t;

endpackage

//--- hw/seq_pkg.sv
package seq_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_SCALE = 2'd1,
        SEQ_PACK  = 2'd2,
        SEQ_HOLD  = 2'd3
    } seq_state_t;

    // grid row walk
    localparam matrix_pkg::dim_t FIRST_ROW = 3'd0;
    localparam matrix_pkg::dim_t LAST_ROW  = 3'd4;

endpackage

//--- hw/matrix_order.sv
`timescale 1ns/1ps

module matrix_order (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              capture,
    input  logic              clear,
    input  matrix_pkg::flat_t data_in,
    input  matrix_pkg::dim_t  r,
    input  matrix_pkg::dim_t  c,
    input  matrix_pkg::dim_t  row_sel,
    output matrix_pkg::row_t  grid_row,
    output matrix_pkg::dim_t  r_out,
    output matrix_pkg::dim_t  c_out
);

    matrix_pkg::grid_t grid_q;
    matrix_pkg::grid_t grid_next;

    // cell (i, j) takes flat cell i*c + j inside the r by c window
    always_comb begin
        grid_next = '0;
        for (int i = 0; i < matrix_pkg::MAX_DIM; i++) begin
            for (int j = 0; j < matrix_pkg::MAX_DIM; j++) begin
                if (i < r && j < c) begin
                    grid_next[i][j] = data_in[i * c + j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            grid_q <= '0;
        end else if (capture) begin
            grid_q <= grid_next;
        end
    end

    // sizes are latched with the grid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_out <= '0;
            c_out <= '0;
        end else if (clear) begin
            r_out <= '0;
            c_out <= '0;
        end else if (capture) begin
            r_out <= r;
            c_out <= c;
        end
    end

    // zero latency row select
    assign grid_row = grid_q[row_sel];

endmodule

//--- hw/row_scaler.sv
`timescale 1ns/1ps

module row_scaler (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              en,
    input  matrix_pkg::cell_t scalar,
    input  matrix_pkg::row_t  grid_row,
    output logic              capture,
    output logic              clear,
    output matrix_pkg::dim_t  row_sel,
    output logic              wr_en,
    output matrix_pkg::dim_t  wr_row,
    output matrix_pkg::row_t  wr_data,
    output logic              pack,
    output logic              busy
);

    seq_pkg::seq_state_t state;
    matrix_pkg::dim_t    row_cnt;
    matrix_pkg::cell_t   scalar_q;

    // job starts on the first edge with en high in idle
    assign capture = en && (state == seq_pkg::SEQ_IDLE);
    assign clear   = !en;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= seq_pkg::SEQ_IDLE;
            row_cnt <= seq_pkg::FIRST_ROW;
        end else if (!en) begin
            // abort or release, back to idle
            state   <= seq_pkg::SEQ_IDLE;
            row_cnt <= seq_pkg::FIRST_ROW;
        end else begin
            case (state)
                seq_pkg::SEQ_IDLE: begin
                    state   <= seq_pkg::SEQ_SCALE;
                    row_cnt <= seq_pkg::FIRST_ROW;
                end
                seq_pkg::SEQ_SCALE: begin
                    if (row_cnt == seq_pkg::LAST_ROW) begin
                        state <= seq_pkg::SEQ_PACK;
                    end else begin
                        row_cnt <= row_cnt + 3'd1;
                    end
                end
                seq_pkg::SEQ_PACK: begin
                    state <= seq_pkg::SEQ_HOLD;
                end
                default: begin
                    // hold the result until en drops
                    state <= seq_pkg::SEQ_HOLD;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            scalar_q <= scalar;
        end
    end

    assign row_sel = row_cnt;
    assign wr_row  = row_cnt;
    assign wr_en   = (state == seq_pkg::SEQ_SCALE);
    assign pack    = (state == seq_pkg::SEQ_PACK);

    // five multipliers, low 9 bits of each product kept
    for (genvar j = 0; j < matrix_pkg::MAX_DIM; j++) begin : g_mul
        assign wr_data[j] = grid_row[j] * scalar_q;
    end

    assign busy = en && (state == seq_pkg::SEQ_SCALE || state == seq_pkg::SEQ_PACK);

endmodule

//--- hw/result_buffer.sv
`timescale 1ns/1ps

module result_buffer (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              clear,
    input  logic              wr_en,
    input  matrix_pkg::dim_t  wr_row,
    input  matrix_pkg::row_t  wr_data,
    output matrix_pkg::grid_t grid
);

    matrix_pkg::grid_t rows_q;

    // one row per write, clear wins over a write in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rows_q <= '0;
        end else if (clear) begin
            rows_q <= '0;
        end else if (wr_en) begin
            rows_q[wr_row] <= wr_data;
        end
    end

    assign grid = rows_q;

endmodule

//--- hw/matrix_restore.sv
`timescale 1ns/1ps

module matrix_restore (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              pack,
    input  logic              clear,
    input  matrix_pkg::grid_t grid,
    input  matrix_pkg::dim_t  r,
    input  matrix_pkg::dim_t  c,
    output matrix_pkg::flat_t data_out
);

    matrix_pkg::flat_t packed_list;

    // grid cell (i, j) lands at flat slot i*c + j
    // slots past r*c stay zero
    always_comb begin
        packed_list = '0;
        for (int i = 0; i < matrix_pkg::MAX_DIM; i++) begin
            for (int j = 0; j < matrix_pkg::MAX_DIM; j++) begin
                if (i < r && j < c) begin
                    packed_list[i * c + j] = grid[i][j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end else if (clear) begin
            data_out <= '0;
        end else if (pack) begin
            data_out <= packed_list;
        end
    end

endmodule

//--- hw/matrix_scalar.sv
`timescale 1ns/1ps

module matrix_scalar (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              en,
    input  matrix_pkg::dim_t  r,
    input  matrix_pkg::dim_t  c,
    input  matrix_pkg::cell_t scalar,
    input  matrix_pkg::flat_t data_in,
    output matrix_pkg::dim_t  r_out,
    output matrix_pkg::dim_t  c_out,
    output matrix_pkg::flat_t data_out,
    output logic              busy
);

    // sequencer strobes
    logic capture;
    logic clear;
    logic pack;

    // grid row feed into the multipliers
    matrix_pkg::dim_t row_sel;
    matrix_pkg::row_t grid_row;

    // scaled row writes
    logic              wr_en;
    matrix_pkg::dim_t  wr_row;
    matrix_pkg::row_t  wr_data;
    matrix_pkg::grid_t scaled_grid;

    matrix_order u_order (
        .clk      (clk),
        .reset_n  (reset_n),
        .capture  (capture),
        .clear    (clear),
        .data_in  (data_in),
        .r        (r),
        .c        (c),
        .row_sel  (row_sel),
        .grid_row (grid_row),
        .r_out    (r_out),
        .c_out    (c_out)
    );

    row_scaler u_scaler (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .scalar   (scalar),
        .grid_row (grid_row),
        .capture  (capture),
        .clear    (clear),
        .row_sel  (row_sel),
        .wr_en    (wr_en),
        .wr_row   (wr_row),
        .wr_data  (wr_data),
        .pack     (pack),
        .busy     (busy)
    );

    result_buffer u_buffer (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (clear),
        .wr_en    (wr_en),
        .wr_row   (wr_row),
        .wr_data  (wr_data),
        .grid     (scaled_grid)
    );

    // packs with the sizes latched at capture
    matrix_restore u_restore (
        .clk      (clk),
        .reset_n  (reset_n),
        .pack     (pack),
        .clear    (clear),
        .grid     (scaled_grid),
        .r        (r_out),
        .c        (c_out),
        .data_out (data_out)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release away from the clock edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;
    end

endmodule

//--- test/matrix_scalar_props.sv
`timescale 1ns/1ps

module matrix_scalar_props (
    input logic              clk,
    input logic              reset_n,
    input logic              en,
    input logic              busy,
    input matrix_pkg::flat_t data_out
);

    // no activity while held in reset
    busy_low_in_reset: assert property (
        @(posedge clk) disable iff (!reset_n)
        !reset_n |-> !busy
    ) else $error("busy high during reset");

    // en low sends the sequencer to idle, so busy waits for a capture
    busy_needs_en: assert property (
        @(posedge clk) disable iff (!reset_n)
        !en |=> !busy
    ) else $error("busy high in the cycle after en was low");

    // a finished job stays finished until released
    busy_stays_low: assert property (
        @(posedge clk) disable iff (!reset_n)
        ($fell(busy) && en) |-> (!busy until !en)
    ) else $error("busy rose again before en fell");

    outputs_cleared: assert property (
        @(posedge clk) disable iff (!reset_n)
        !en |=> (data_out == '0)
    ) else $error("data_out not cleared one cycle after en fell");

endmodule

bind matrix_scalar matrix_scalar_props u_props (
    .clk      (clk),
    .reset_n  (reset_n),
    .en       (en),
    .busy     (busy),
    .data_out (data_out)
);

//--- test/tb_matrix_scalar.sv
`timescale 1ns/1ps

module tb_matrix_scalar;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int SAMPLE_DELAY = 1;
    localparam int DRIVE_DELAY  = 2;
    localparam int RANDOM_JOBS  = 200;
    localparam int EDGE_JOBS    = 4;
    localparam int ABORT_JOBS   = 12;
    // every abort is followed by a full job
    localparam int TOTAL_JOBS   = RANDOM_JOBS + EDGE_JOBS + 2 * ABORT_JOBS;
    localparam int JOB_CYCLES   = 20;
    localparam longint TIMEOUT_NS =
        2 * (TOTAL_JOBS * JOB_CYCLES + RESET_CYCLES) * CLK_PERIOD;
    localparam int FLAT_BITS    = $bits(matrix_pkg::flat_t);

    logic              clk;
    logic              reset_n;
    logic              en;
    matrix_pkg::dim_t  r;
    matrix_pkg::dim_t  c;
    matrix_pkg::cell_t scalar;
    matrix_pkg::flat_t data_in;
    matrix_pkg::dim_t  r_out;
    matrix_pkg::dim_t  c_out;
    matrix_pkg::flat_t data_out;
    logic              busy;

    logic [31:0] lfsr;
    int          error_count;

    tb_clock #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    matrix_scalar u_matrix_scalar (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r        (r),
        .c        (c),
        .scalar   (scalar),
        .data_in  (data_in),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out),
        .busy     (busy)
    );

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_size(output matrix_pkg::dim_t s);
        logic [31:0] v;
        take_bits(8, v);
        s = matrix_pkg::dim_t'(v % matrix_pkg::MAX_DIM + 1);
    endtask

    task automatic random_cell(output matrix_pkg::cell_t x);
        logic [31:0] v;
        take_bits(matrix_pkg::DATA_WIDTH, v);
        x = matrix_pkg::cell_t'(v);
    endtask

    task automatic fill_flat(output matrix_pkg::flat_t f);
        matrix_pkg::cell_t x;
        for (int k = 0; k < matrix_pkg::CELL_COUNT; k++) begin
            random_cell(x);
            f[k] = x;
        end
    endtask

    // slot k below r*c holds the low bits of data k times the scalar
    function automatic matrix_pkg::flat_t expected_flat(
        input matrix_pkg::flat_t din,
        input matrix_pkg::dim_t  rows,
        input matrix_pkg::dim_t  cols,
        input matrix_pkg::cell_t s
    );
        matrix_pkg::flat_t                   result;
        logic [2*matrix_pkg::DATA_WIDTH-1:0] prod;
        result = '0;
        for (int k = 0; k < matrix_pkg::CELL_COUNT; k++) begin
            if (k < rows * cols) begin
                prod = din[k] * s;
                result[k] = prod[matrix_pkg::DATA_WIDTH-1:0];
            end
        end
        return result;
    endfunction

    task automatic compare(input string what, input logic [FLAT_BITS-1:0] got,
                           input logic [FLAT_BITS-1:0] want);
        if (got !== want) begin
            error_count++;
            $display("error %0t ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_outputs(input string tag, input matrix_pkg::dim_t er,
                                 input matrix_pkg::dim_t ec, input logic eb,
                                 input matrix_pkg::flat_t ed);
        compare($sformatf("%s busy", tag), busy, eb);
        compare($sformatf("%s r_out", tag), r_out, er);
        compare($sformatf("%s c_out", tag), c_out, ec);
        for (int k = 0; k < matrix_pkg::CELL_COUNT; k++) begin
            compare($sformatf("%s data_out[%0d]", tag, k), data_out[k], ed[k]);
        end
    endtask

    task automatic sample_point();
        @(posedge clk);
        #(SAMPLE_DELAY);
    endtask

    task automatic drive_point();
        #(DRIVE_DELAY - SAMPLE_DELAY);
    endtask

    // inputs the DUT must ignore while a job runs
    task automatic drive_noise();
        matrix_pkg::dim_t  nr;
        matrix_pkg::dim_t  nc;
        matrix_pkg::cell_t ns;
        matrix_pkg::flat_t nd;
        random_size(nr);
        random_size(nc);
        random_cell(ns);
        fill_flat(nd);
        r = nr;
        c = nc;
        scalar = ns;
        data_in = nd;
    endtask

    task automatic run_job(input matrix_pkg::dim_t jr, input matrix_pkg::dim_t jc,
                           input matrix_pkg::cell_t js, input matrix_pkg::flat_t jd,
                           input int hold_cycles);
        matrix_pkg::flat_t want;
        want = expected_flat(jd, jr, jc, js);
        en = 1'b1;
        r = jr;
        c = jc;
        scalar = js;
        data_in = jd;
        // edge N captures, busy through N+5
        for (int e = 0; e <= 5; e++) begin
            sample_point();
            check_outputs($sformatf("edge N+%0d", e), jr, jc, 1'b1, '0);
            drive_point();
            drive_noise();
        end
        sample_point();
        check_outputs("edge N+6", jr, jc, 1'b0, want);
        for (int h = 0; h < hold_cycles; h++) begin
            drive_point();
            drive_noise();
            sample_point();
            check_outputs("hold", jr, jc, 1'b0, want);
        end
        drive_point();
        en = 1'b0;
        sample_point();
        check_outputs("release", '0, '0, 1'b0, '0);
        drive_point();
    endtask

    task automatic random_job();
        matrix_pkg::dim_t  jr;
        matrix_pkg::dim_t  jc;
        matrix_pkg::cell_t js;
        matrix_pkg::flat_t jd;
        logic [31:0]       hold;
        random_size(jr);
        random_size(jc);
        random_cell(js);
        fill_flat(jd);
        take_bits(2, hold);
        run_job(jr, jc, js, jd, int'(hold));
    endtask

    task automatic edge_job(input matrix_pkg::dim_t jr, input matrix_pkg::dim_t jc,
                            input matrix_pkg::cell_t js);
        matrix_pkg::flat_t jd;
        fill_flat(jd);
        run_job(jr, jc, js, jd, 1);
    endtask

    task automatic abort_job();
        matrix_pkg::dim_t  jr;
        matrix_pkg::dim_t  jc;
        logic [31:0]       v;
        int                stop;
        random_size(jr);
        random_size(jc);
        take_bits(8, v);
        stop = int'(v % 6);
        en = 1'b1;
        r = jr;
        c = jc;
        drive_noise();
        r = jr;
        c = jc;
        sample_point();
        check_outputs("abort edge N", jr, jc, 1'b1, '0);
        for (int e = 0; e < stop; e++) begin
            drive_point();
            drive_noise();
            sample_point();
            check_outputs("abort run", jr, jc, 1'b1, '0);
        end
        drive_point();
        en = 1'b0;
        sample_point();
        check_outputs("abort", '0, '0, 1'b0, '0);
        drive_point();
        random_job();
    endtask

    initial begin
        matrix_pkg::dim_t sr;
        matrix_pkg::dim_t sc;
        lfsr = 32'hfe074ed7;
        error_count = 0;
        en = 1'b0;
        r = 3'd1;
        c = 3'd1;
        scalar = '0;
        data_in = '0;
        wait (reset_n === 1'b1);
        sample_point();
        check_outputs("after reset", '0, '0, 1'b0, '0);
        drive_point();
        for (int j = 0; j < RANDOM_JOBS; j++) begin
            random_job();
        end
        edge_job(3'd5, 3'd5, 9'h0a7);
        edge_job(3'd1, 3'd1, 9'h133);
        random_size(sr);
        random_size(sc);
        edge_job(sr, sc, '0);
        random_size(sr);
        random_size(sc);
        edge_job(sr, sc, '1);
        for (int j = 0; j < ABORT_JOBS; j++) begin
            abort_job();
        end
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- matrix_scalar.f
hw/matrix_pkg.sv
hw/seq_pkg.sv
hw/matrix_order.sv
hw/row_scaler.sv
hw/result_buffer.sv
hw/matrix_restore.sv
hw/matrix_scalar.sv
test/tb_clock.sv
test/matrix_scalar_props.sv
test/tb_matrix_scalar.sv

//--- Bender.yml
package:
  name: matrix_scalar

sources:
  # packages first, then the blocks and the top level
  - files:
      - hw/matrix_pkg.sv
      - hw/seq_pkg.sv
      - hw/matrix_order.sv
      - hw/row_scaler.sv
      - hw/result_buffer.sv
      - hw/matrix_restore.sv
      - hw/matrix_scalar.sv

  - target: test
    files:
      - test/tb_clock.sv
      - test/matrix_scalar_props.sv
      - test/tb_matrix_scalar.sv
